// File: logic/soc_params.svh
// Fixed 32-bit bus with the slave region in the top address nibble and word-aligned RAM accesses
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// slave select taken from the upper address nibble
`define SOC_REGION_W     4
`define SOC_REGION_RAM   4'h1
`define SOC_REGION_TIMER 4'h2

// ram depth in words, indexed from address bit 2 upward
`define SOC_RAM_WORDS 1024

// timer register byte offsets within the low address byte
`define SOC_TIMER_CTRL  8'h00
`define SOC_TIMER_COUNT 8'h04
`define SOC_TIMER_VALUE 8'h08

// timer control register width
`define SOC_TIMER_CTRL_W 3

`endif

// File: logic/soc_pkg.sv
// Bus types shared by masters, interconnect and slaves; requests are plain levels without acknowledge
`include "soc_params.svh"

package soc_pkg;

    // one data word on the bus
    typedef logic [`SOC_DATA_W-1:0] bus_word_t;

    // byte address
    typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;

    // request from a master, or slave select from the bus
    typedef struct packed {
        logic      req;
        logic      we;
        bus_addr_t addr;
        bus_word_t wdata;
    } bus_req_t;

    // timer control bits, msb first
    typedef struct packed {
        // sticky until cleared by writing 1
        logic pend;
        logic irq_en;
        logic cnt_en;
    } timer_ctrl_t;

endpackage

// File: logic/sys_bus.sv
// Combinational two-master bus; debug always wins and a held core request gets no service
`include "soc_params.svh"

module sys_bus (
    input  logic                clk,
    input  logic                rst_i,

    // masters
    input  soc_pkg::bus_req_t   core_req_i,
    input  soc_pkg::bus_req_t   dbg_req_i,
    output soc_pkg::bus_word_t  core_rdata_o,
    output soc_pkg::bus_word_t  dbg_rdata_o,
    output logic                core_hold_o,

    // slaves
    output soc_pkg::bus_req_t   ram_req_o,
    input  soc_pkg::bus_word_t  ram_rdata_i,
    output soc_pkg::bus_req_t   timer_req_o,
    input  soc_pkg::bus_word_t  timer_rdata_i
);

    logic                     dbg_own;
    logic                     core_own;
    soc_pkg::bus_req_t        win_req;
    logic [`SOC_REGION_W-1:0] region;
    logic                     sel_ram;
    logic                     sel_timer;
    soc_pkg::bus_word_t       win_rdata;

    // fixed priority, debug first
    assign dbg_own  = dbg_req_i.req;
    assign core_own = core_req_i.req & ~dbg_req_i.req;

    // core stalls whenever debug is on the bus
    assign core_hold_o = dbg_req_i.req;

    assign win_req = dbg_own ? dbg_req_i : core_req_i;

    // region decode
    assign region    = win_req.addr[`SOC_ADDR_W-1 -: `SOC_REGION_W];
    assign sel_ram   = win_req.req && (region == `SOC_REGION_RAM);
    assign sel_timer = win_req.req && (region == `SOC_REGION_TIMER);

    // address and data fan out, only the decoded slave sees req
    always_comb begin
        ram_req_o       = win_req;
        ram_req_o.req   = sel_ram;
        timer_req_o     = win_req;
        timer_req_o.req = sel_timer;
    end

    // read return, zero for unmapped regions
    always_comb begin
        if (sel_ram) begin
            win_rdata = ram_rdata_i;
        end else if (sel_timer) begin
            win_rdata = timer_rdata_i;
        end else begin
            win_rdata = '0;
        end
    end

    // the losing master reads zero
    assign dbg_rdata_o  = dbg_own  ? win_rdata : '0;
    assign core_rdata_o = core_own ? win_rdata : '0;

endmodule

// File: logic/data_ram.sv
// Word RAM without byte enables or reset; contents are undefined until written
`include "soc_params.svh"

module data_ram (
    input  logic               clk,
    input  soc_pkg::bus_req_t  ram_req_i,
    output soc_pkg::bus_word_t rdata_o
);

    localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

    soc_pkg::bus_word_t mem [`SOC_RAM_WORDS];

    logic [IDX_W-1:0] idx;
    logic             wr;

    // word index, region bits already decoded by the bus
    assign idx = ram_req_i.addr[IDX_W+1:2];

    assign wr = ram_req_i.req & ram_req_i.we;

    // write lands on the first edge of the request
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[idx] <= ram_req_i.wdata;
        end
    end

    // asynchronous read in the request cycle
    assign rdata_o = mem[idx];

endmodule

// File: logic/timer.sv
// Single timer with wrap on compare; only the low address byte selects a register
`include "soc_params.svh"

module timer (
    input  logic               clk,
    input  logic               rst_i,
    input  soc_pkg::bus_req_t  timer_req_i,
    output soc_pkg::bus_word_t rdata_o,
    output logic               irq_o
);

    soc_pkg::timer_ctrl_t ctrl;
    soc_pkg::bus_word_t   count;
    soc_pkg::bus_word_t   value;

    logic [7:0] offs;
    logic       wr;
    logic       wr_ctrl;
    logic       wr_count;
    logic       wr_value;
    logic       hit;

    assign offs = timer_req_i.addr[7:0];
    assign wr   = timer_req_i.req & timer_req_i.we;

    assign wr_ctrl  = wr && (offs == `SOC_TIMER_CTRL);
    assign wr_count = wr && (offs == `SOC_TIMER_COUNT);
    assign wr_value = wr && (offs == `SOC_TIMER_VALUE);

    // compare match while counting
    assign hit = ctrl.cnt_en && (count == value);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl  <= '0;
            count <= '0;
            value <= '0;
        end else begin
            if (wr_ctrl) begin
                ctrl.cnt_en <= timer_req_i.wdata[0];
                ctrl.irq_en <= timer_req_i.wdata[1];
            end

            // a clear write wins over a match in the same cycle
            if (wr_ctrl && timer_req_i.wdata[2]) begin
                ctrl.pend <= 1'b0;
            end else if (hit) begin
                ctrl.pend <= 1'b1;
            end

            if (wr_count) begin
                count <= timer_req_i.wdata;
            end else if (hit) begin
                count <= '0;
            end else if (ctrl.cnt_en) begin
                count <= count + 1'b1;
            end

            if (wr_value) begin
                value <= timer_req_i.wdata;
            end
        end
    end

    // register readback, unused offsets read zero
    always_comb begin
        rdata_o = '0;
        case (offs)
            `SOC_TIMER_CTRL:  rdata_o[`SOC_TIMER_CTRL_W-1:0] = ctrl;
            `SOC_TIMER_COUNT: rdata_o = count;
            `SOC_TIMER_VALUE: rdata_o = value;
            default:          rdata_o = '0;
        endcase
    end

    assign irq_o = ctrl.pend & ctrl.irq_en;

endmodule

// File: logic/soc_top.sv
// System bus with RAM at region 1 and timer at region 2; masters are external to this level
module soc_top (
    input  logic               clk,
    input  logic               rst_i,

    // bus masters
    input  soc_pkg::bus_req_t  core_req_i,
    input  soc_pkg::bus_req_t  dbg_req_i,
    output soc_pkg::bus_word_t core_rdata_o,
    output soc_pkg::bus_word_t dbg_rdata_o,
    output logic               core_hold_o,

    output logic               timer_irq_o
);

    // slave side of the bus
    soc_pkg::bus_req_t  ram_req;
    soc_pkg::bus_word_t ram_rdata;
    soc_pkg::bus_req_t  timer_req;
    soc_pkg::bus_word_t timer_rdata;

    sys_bus bus_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .core_req_i    (core_req_i),
        .dbg_req_i     (dbg_req_i),
        .core_rdata_o  (core_rdata_o),
        .dbg_rdata_o   (dbg_rdata_o),
        .core_hold_o   (core_hold_o),
        .ram_req_o     (ram_req),
        .ram_rdata_i   (ram_rdata),
        .timer_req_o   (timer_req),
        .timer_rdata_i (timer_rdata)
    );

    data_ram ram_i (
        .clk       (clk),
        .ram_req_i (ram_req),
        .rdata_o   (ram_rdata)
    );

    timer timer_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .timer_req_i (timer_req),
        .rdata_o     (timer_rdata),
        .irq_o       (timer_irq_o)
    );

endmodule

// File: dv/soc_assert.sv
// Bound to soc_top since the timer enable lives beside the bus; checks are off while reset is high
module soc_assert (
    input logic                 clk,
    input logic                 rst_i,
    input soc_pkg::bus_req_t    dbg_req_i,
    input logic                 core_hold_i,
    input soc_pkg::bus_req_t    ram_req_i,
    input soc_pkg::bus_req_t    timer_req_i,
    input soc_pkg::timer_ctrl_t timer_ctrl_i,
    input logic                 timer_irq_i
);

    // core stalls exactly while debug requests
    hold_follows_dbg: assert property (@(posedge clk) disable iff (rst_i)
        core_hold_i == dbg_req_i.req)
        else $error("core hold flag differs from the debug request");

    // never two slaves selected
    one_slave_sel: assert property (@(posedge clk) disable iff (rst_i)
        !(ram_req_i.req && timer_req_i.req))
        else $error("RAM and timer selected in the same cycle");

    irq_needs_enable: assert property (@(posedge clk) disable iff (rst_i)
        timer_irq_i |-> timer_ctrl_i.irq_en)
        else $error("timer interrupt high with its enable clear");

endmodule

bind soc_top soc_assert assert_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .dbg_req_i    (dbg_req_i),
    .core_hold_i  (core_hold_o),
    .ram_req_i    (ram_req),
    .timer_req_i  (timer_req),
    .timer_ctrl_i (timer_i.ctrl),
    .timer_irq_i  (timer_irq_o)
);

// File: dv/soc_tb.sv
// Run from the project root so dv/soc_tests.txt is found; each access holds its request for one clock
module soc_tb;

    localparam int TEST_LINES   = 64;
    localparam int TEST_COLS    = 5;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 16;

    // operation codes of the test file
    localparam logic [31:0] OP_WRITE      = 32'h1;
    localparam logic [31:0] OP_WRITE_RAND = 32'h2;
    localparam logic [31:0] OP_READ       = 32'h3;
    localparam logic [31:0] OP_READ_RAND  = 32'h4;
    localparam logic [31:0] OP_PAIR       = 32'h5;
    localparam logic [31:0] OP_WAIT_IRQ   = 32'h6;
    localparam logic [31:0] OP_IRQ_LEVEL  = 32'h7;
    localparam logic [31:0] OP_END        = 32'hf;

    logic               clk;
    logic               rst_i;
    soc_pkg::bus_req_t  core_req;
    soc_pkg::bus_req_t  dbg_req;
    soc_pkg::bus_word_t core_rdata;
    soc_pkg::bus_word_t dbg_rdata;
    logic               core_hold;
    logic               timer_irq;

    // five words per test line: op, master, addr, data, expect
    logic [31:0]        test_mem [TEST_LINES*TEST_COLS];
    soc_pkg::bus_word_t last_rand;
    int                 errors;

    soc_top dut_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .core_req_i   (core_req),
        .dbg_req_i    (dbg_req),
        .core_rdata_o (core_rdata),
        .dbg_rdata_o  (dbg_rdata),
        .core_hold_o  (core_hold),
        .timer_irq_o  (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        errors++;
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input soc_pkg::bus_word_t got, input soc_pkg::bus_word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s gave %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_hold(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: core hold on %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    function automatic soc_pkg::bus_req_t make_req(input logic we, input soc_pkg::bus_addr_t addr,
                                                   input soc_pkg::bus_word_t wdata);
        soc_pkg::bus_req_t r;
        r.req   = 1'b1;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    task automatic drive_idle();
        core_req = '0;
        dbg_req  = '0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        drive_idle();
        #SAMPLE_DELAY;
    endtask

    // one master alone on the bus for one cycle
    task automatic single_access(input logic is_dbg, input logic we, input soc_pkg::bus_addr_t addr,
                                 input soc_pkg::bus_word_t wdata,
                                 output soc_pkg::bus_word_t rdata);
        @(posedge clk);
        #DRIVE_DELAY;
        if (is_dbg) begin
            dbg_req  = make_req(we, addr, wdata);
            core_req = '0;
        end else begin
            core_req = make_req(we, addr, wdata);
            dbg_req  = '0;
        end
        #SAMPLE_DELAY;
        check_hold(core_hold, is_dbg, $sformatf("access to %h", addr));
        if (is_dbg) begin
            rdata = dbg_rdata;
            check_word(core_rdata, '0, "idle core read data");
        end else begin
            rdata = core_rdata;
            check_word(dbg_rdata, '0, "idle debug read data");
        end
    endtask

    // both masters write the same address in the same cycle
    task automatic pair_access(input soc_pkg::bus_addr_t addr, input soc_pkg::bus_word_t dbg_data,
                               input soc_pkg::bus_word_t core_data);
        @(posedge clk);
        #DRIVE_DELAY;
        dbg_req  = make_req(1'b1, addr, dbg_data);
        core_req = make_req(1'b1, addr, core_data);
        #SAMPLE_DELAY;
        check_hold(core_hold, 1'b1, "concurrent requests");
        check_word(core_rdata, '0, "core read data while debug owns the bus");
    endtask

    task automatic wait_irq_rise(input int limit);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < limit) begin
            idle_cycle();
            waited++;
            seen = (timer_irq === 1'b1);
        end
        if (!seen) begin
            $display("timer interrupt did not rise within %0d cycles", limit);
            stop_run();
        end
    endtask

    task automatic watch_irq_low(input int limit);
        for (int i = 0; i < limit; i++) begin
            idle_cycle();
            check_irq(timer_irq, 1'b0, "timer interrupt with its enable clear");
        end
    endtask

    task automatic run_line(input int base);
        logic [31:0]        op;
        logic [31:0]        master;
        logic [31:0]        addr;
        logic [31:0]        data;
        logic [31:0]        exp;
        soc_pkg::bus_word_t rdata;
        op     = test_mem[base];
        master = test_mem[base+1];
        addr   = test_mem[base+2];
        data   = test_mem[base+3];
        exp    = test_mem[base+4];
        case (op)
            OP_WRITE: begin
                single_access(master[0], 1'b1, addr, data, rdata);
            end
            OP_WRITE_RAND: begin
                last_rand = $urandom;
                single_access(master[0], 1'b1, addr, last_rand, rdata);
            end
            OP_READ: begin
                single_access(master[0], 1'b0, addr, '0, rdata);
                check_word(rdata, exp, $sformatf("read of %h", addr));
            end
            OP_READ_RAND: begin
                single_access(master[0], 1'b0, addr, '0, rdata);
                check_word(rdata, last_rand, $sformatf("read of random word at %h", addr));
            end
            OP_PAIR: begin
                pair_access(addr, data, exp);
            end
            OP_WAIT_IRQ: begin
                if (exp[0]) begin
                    wait_irq_rise(int'(data));
                end else begin
                    watch_irq_low(int'(data));
                end
            end
            OP_IRQ_LEVEL: begin
                idle_cycle();
                check_irq(timer_irq, exp[0], "timer interrupt level");
            end
            default: begin
                $display("unknown operation %h in test line %0d", op, base / TEST_COLS);
                stop_run();
            end
        endcase
    endtask

    initial begin
        int line;
        logic done;
        void'($urandom(32'h9747));
        errors = 0;
        rst_i  = 1'b1;
        drive_idle();
        $readmemh("dv/soc_tests.txt", test_mem);

        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst_i = 1'b0;

        line = 0;
        done = 1'b0;
        while (!done) begin
            if (line >= TEST_LINES) begin
                $display("test file holds no end line within %0d lines", TEST_LINES);
                stop_run();
            end
            if (test_mem[line*TEST_COLS] === OP_END) begin
                done = 1'b1;
            end else begin
                run_line(line * TEST_COLS);
                line++;
            end
        end

        idle_cycle();
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: dv/soc_tests.txt
// columns (hex): op master addr data expect; master 0 is core, 1 is debug
// op 1 write, 2 random write, 3 read, 4 read random, 5 debug+core pair, 6 irq wait, 7 irq level, f end
// timer registers and interrupt after reset
3 0 20000004 00000000 00000000
3 1 20000000 00000000 00000000
3 0 20000008 00000000 00000000
7 0 00000000 00000000 00000000
// RAM write and read back on both ports
1 0 10000000 cafef00d 00000000
1 0 10000004 12345678 00000000
3 0 10000000 00000000 cafef00d
3 1 10000004 00000000 12345678
2 0 10000010 00000000 00000000
4 1 10000010 00000000 00000000
// debug wins, core write data in the expect column
5 0 10000020 a5a5a5a5 5a5a5a5a
3 0 10000020 00000000 a5a5a5a5
// unmapped regions 0 and 3
1 0 00000020 deadbeef 00000000
1 1 30000008 00000077 00000000
1 0 00000000 00000003 00000000
3 0 00000020 00000000 00000000
3 1 30000008 00000000 00000000
3 0 10000020 00000000 a5a5a5a5
3 0 20000008 00000000 00000000
3 1 20000000 00000000 00000000
// timer register access
1 0 20000008 00000005 00000000
3 0 20000008 00000000 00000005
1 0 20000000 00000002 00000000
3 0 20000000 00000000 00000002
3 1 20000004 00000000 00000000
// counting with the interrupt disabled, then enabled
1 0 20000000 00000001 00000000
6 0 00000000 00000040 00000000
3 0 20000000 00000000 00000005
1 0 20000000 00000007 00000000
6 0 00000000 00000040 00000001
3 0 20000000 00000000 00000007
1 0 20000000 00000006 00000000
7 0 00000000 00000000 00000000
f 0 00000000 00000000 00000000

// File: tb.f
+incdir+logic
logic/soc_pkg.sv
logic/sys_bus.sv
logic/data_ram.sv
logic/timer.sv
logic/soc_top.sv
dv/soc_assert.sv
dv/soc_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, log in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module soc_tb \
		-Mdir obj_dir -o soc_tb
	./obj_dir/soc_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
